//--- sim.f
hdl/link_pkg.sv
hdl/mc_pkg.sv
hdl/flit_serializer.sv
hdl/flit_deserializer.sv
hdl/flit_fifo.sv
hdl/channel_tunnel.sv
hdl/noc_io_link.sv
tests/noc_io_link_properties.sv
tests/noc_io_link_tb.sv

//--- Bender.yml
package:
  name: noc_io_link

sources:
  # RTL in compile order
  - hdl/link_pkg.sv
  - hdl/mc_pkg.sv
  - hdl/flit_serializer.sv
  - hdl/flit_deserializer.sv
  - hdl/flit_fifo.sv
  - hdl/channel_tunnel.sv
  - hdl/noc_io_link.sv

  - target: test
    files:
      - tests/noc_io_link_properties.sv
      - tests/noc_io_link_tb.sv

//--- tests/noc_io_link_tb.sv
`timescale 1ns/1ps

module noc_io_link_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int DRIVE_DELAY     = 1;
  localparam int TOTAL_PKTS      = 2 + 32 + 16 + 40;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 200;

  logic                              clk_i;
  logic                              rst_i;
  logic                              fwd_v_i;
  mc_pkg::mc_fwd_pkt_s               fwd_pkt_i;
  logic                              fwd_ready_o;
  logic                              rev_v_i;
  mc_pkg::mc_rev_pkt_s               rev_pkt_i;
  logic                              rev_ready_o;
  logic                              fwd_v_o;
  mc_pkg::mc_fwd_pkt_s               fwd_pkt_o;
  logic                              fwd_ready_i;
  logic                              rev_v_o;
  mc_pkg::mc_rev_pkt_s               rev_pkt_o;
  logic                              rev_ready_i;
  logic                              link_v;
  link_pkg::link_flit_s              link_flit;
  logic [link_pkg::NUM_CHANNELS-1:0] link_credit;

  mc_pkg::mc_fwd_pkt_s exp_fwd [$];   // Expected packets per channel
  mc_pkg::mc_rev_pkt_s exp_rev [$];
  int                  errors;
  int                  fwd_sent;
  int                  fwd_rcvd;
  int                  rev_sent;
  int                  rev_rcvd;
  string               cur_test;
  logic [31:0]         rng_pkt;
  logic [31:0]         rng_rdy;
  logic                rand_done;

  noc_io_link i_dut
    (.clk_i (clk_i), .rst_i (rst_i)
    ,.fwd_v_i (fwd_v_i), .fwd_pkt_i (fwd_pkt_i), .fwd_ready_o (fwd_ready_o)
    ,.rev_v_i (rev_v_i), .rev_pkt_i (rev_pkt_i), .rev_ready_o (rev_ready_o)
    ,.fwd_v_o (fwd_v_o), .fwd_pkt_o (fwd_pkt_o), .fwd_ready_i (fwd_ready_i)
    ,.rev_v_o (rev_v_o), .rev_pkt_o (rev_pkt_o), .rev_ready_i (rev_ready_i)
    ,.link_v_o (link_v), .link_flit_o (link_flit), .link_credit_i (link_credit)
    ,.link_v_i (link_v), .link_flit_i (link_flit), .link_credit_o (link_credit)
    );   // Link looped back on itself

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic compare(input string test, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("ERR %s expected %h actual %h", test, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic make_fwd(output mc_pkg::mc_fwd_pkt_s pkt);
    rng_pkt    = xorshift(rng_pkt);
    pkt.op     = rng_pkt[3:0];
    pkt.addr   = rng_pkt[19:4];
    pkt.x_cord = rng_pkt[23:20];
    pkt.y_cord = rng_pkt[27:24];
    rng_pkt    = xorshift(rng_pkt);
    pkt.data   = rng_pkt;
  endtask

  task automatic make_rev(output mc_pkg::mc_rev_pkt_s pkt);
    rng_pkt      = xorshift(rng_pkt);
    pkt.ret_type = rng_pkt[1:0];
    pkt.x_cord   = rng_pkt[7:4];
    pkt.y_cord   = rng_pkt[11:8];
    rng_pkt      = xorshift(rng_pkt);
    pkt.data     = rng_pkt;
  endtask

  // Ready is read mid cycle, the transfer lands on the next rising edge
  task automatic send_fwd(input int count);
    mc_pkg::mc_fwd_pkt_s pkt;
    for (int i = 0; i < count; i++)
    begin
      make_fwd(pkt);
      fwd_v_i   = 1'b1;
      fwd_pkt_i = pkt;
      @(negedge clk_i);
      while (!fwd_ready_o)
        @(negedge clk_i);
      exp_fwd.push_back(pkt);
      fwd_sent++;
      @(posedge clk_i);
      #DRIVE_DELAY;
      fwd_v_i = 1'b0;
    end
  endtask

  task automatic send_rev(input int count);
    mc_pkg::mc_rev_pkt_s pkt;
    for (int i = 0; i < count; i++)
    begin
      make_rev(pkt);
      rev_v_i   = 1'b1;
      rev_pkt_i = pkt;
      @(negedge clk_i);
      while (!rev_ready_o)
        @(negedge clk_i);
      exp_rev.push_back(pkt);
      rev_sent++;
      @(posedge clk_i);
      #DRIVE_DELAY;
      rev_v_i = 1'b0;
    end
  endtask

  // Idle tail catches any extra packet
  task automatic drain_and_count();
    while (exp_fwd.size() != 0 || exp_rev.size() != 0)
      @(negedge clk_i);
    repeat (20) @(posedge clk_i);
    #DRIVE_DELAY;
    compare({cur_test, " fwd count"}, fwd_sent, fwd_rcvd);
    compare({cur_test, " rev count"}, rev_sent, rev_rcvd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk_i)
  begin
    if (!rst_i && fwd_v_o && fwd_ready_i)
    begin
      fwd_rcvd++;
      if (exp_fwd.size() == 0)
      begin
        $display("Forward packet %h arrived that was never sent (%s)", fwd_pkt_o, cur_test);
        errors++;
      end
      else
        compare(cur_test, exp_fwd.pop_front(), fwd_pkt_o);
    end
    if (!rst_i && rev_v_o && rev_ready_i)
    begin
      rev_rcvd++;
      if (exp_rev.size() == 0)
      begin
        $display("Return packet %h arrived that was never sent (%s)", rev_pkt_o, cur_test);
        errors++;
      end
      else
        compare(cur_test, exp_rev.pop_front(), rev_pkt_o);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    cur_test = "reset_state";
    @(negedge clk_i);
    compare(cur_test, 1, fwd_ready_o);
    compare(cur_test, 1, rev_ready_o);
    compare(cur_test, 0, fwd_v_o);
    compare(cur_test, 0, rev_v_o);
    compare(cur_test, 0, link_v);
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic test_single();
    cur_test = "single";
    send_fwd(1);
    drain_and_count();
    send_rev(1);
    drain_and_count();
  endtask

  task automatic test_interleave();
    cur_test = "interleave";
    fork
      send_fwd(16);
      send_rev(16);
    join
    drain_and_count();
  endtask

  task automatic test_backpressure();
    int fwd_base;
    int n;
    cur_test    = "backpressure";
    fwd_base    = fwd_sent;
    fwd_ready_i = 1'b0;
    fork
      send_fwd(8);
      begin
        send_rev(8);
        while (exp_rev.size() != 0)
          @(negedge clk_i);
        n = 0;
        while (fwd_ready_o && n < 50)
        begin
          @(negedge clk_i);
          n++;
        end
        if (fwd_ready_o)
        begin
          $display("Forward input never stalled while its output was held");
          errors++;
        end
        // One packet held at the output, one in the receive FIFO, one in the serializer
        compare({cur_test, " fwd accepted during stall"}, 3, fwd_sent - fwd_base);
        @(posedge clk_i);
        #DRIVE_DELAY;
        fwd_ready_i = 1'b1;
      end
    join
    drain_and_count();
  endtask

  task automatic test_random_ready();
    cur_test  = "random_ready";
    rand_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 40; i++)
        begin
          rng_pkt = xorshift(rng_pkt);
          if (rng_pkt[0])
            send_fwd(1);
          else
            send_rev(1);
        end
        while (exp_fwd.size() != 0 || exp_rev.size() != 0)
          @(negedge clk_i);
        rand_done = 1'b1;
      end
      while (!rand_done)
      begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        rng_rdy     = xorshift(rng_rdy);
        fwd_ready_i = rng_rdy[0];
        rev_ready_i = rng_rdy[1];
      end
    join
    fwd_ready_i = 1'b1;
    rev_ready_i = 1'b1;
    drain_and_count();
  endtask

  initial
  begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    fwd_v_i     = 1'b0;
    fwd_pkt_i   = '0;
    rev_v_i     = 1'b0;
    rev_pkt_i   = '0;
    fwd_ready_i = 1'b1;
    rev_ready_i = 1'b1;
    rng_pkt     = 32'he8bd2c9a;
    rng_rdy     = xorshift(32'he8bd2c9a ^ 32'h5a5a5a5a);  // Separate stream for readies
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    test_reset_state();
    test_single();
    test_interleave();
    test_backpressure();
    test_random_ready();
    errors += i_dut.tunnel.i_props.fail_count;
    $display("Summary: %0d errors, forward %0d/%0d, return %0d/%0d packets received",
             errors, fwd_rcvd, fwd_sent, rev_rcvd, rev_sent);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    #((WATCHDOG_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired in test %s, packets stopped arriving", cur_test);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- tests/noc_io_link_properties.sv
`timescale 1ns/1ps

module noc_io_link_properties
  (input  logic                                                         clk_i
  ,input  logic                                                         rst_i
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]                            fifo_push_i
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]                            fifo_full_i
  ,input  logic [link_pkg::NUM_CHANNELS-1:0][link_pkg::CREDIT_WIDTH-1:0] credit_i
  ,input  logic                                                         link_v_i
  ,input  link_pkg::link_flit_s                                         link_flit_i
  );

  int fail_count = 0;

  for (genvar c = 0; c < link_pkg::NUM_CHANNELS; c++)
  begin : g_chan
    a_no_push_full : assert property (@(posedge clk_i) disable iff (rst_i)
      fifo_push_i[c] |-> !fifo_full_i[c])
      else
      begin
        fail_count++;
        $error("Channel %0d receive FIFO pushed while full", c);
      end

    // A counter that drops below zero wraps above the limit
    a_credit_range : assert property (@(posedge clk_i) disable iff (rst_i)
      credit_i[c] <= link_pkg::CREDIT_MAX)
      else
      begin
        fail_count++;
        $error("Channel %0d credit count %0d out of range", c, credit_i[c]);
      end

    // Flit on the wire, tagged for this channel, was issued against a credit
    a_send_needs_credit : assert property (@(posedge clk_i) disable iff (rst_i)
      (link_v_i && (int'(link_flit_i.chan) == c)) |-> ($past(credit_i[c]) != '0))
      else
      begin
        fail_count++;
        $error("Channel %0d sent a flit with no credit", c);
      end
  end

  a_link_idle_in_reset : assert property (@(posedge clk_i) rst_i |=> !link_v_i)
    else
    begin
      fail_count++;
      $error("Link valid high while in reset");
    end

endmodule

bind channel_tunnel noc_io_link_properties i_props
  (.clk_i       (clk_i)
  ,.rst_i       (rst_i)
  ,.fifo_push_i (fifo_push)
  ,.fifo_full_i (fifo_full)
  ,.credit_i    ({credit_r[1], credit_r[0]})
  ,.link_v_i    (link_v_o)
  ,.link_flit_i (link_flit_o)
  );

//--- hdl/noc_io_link.sv
`timescale 1ns/1ps

module noc_io_link
  (input  logic                                clk_i
  ,input  logic                                rst_i

  // Core side inputs
  ,input  logic                                fwd_v_i
  ,input  mc_pkg::mc_fwd_pkt_s                 fwd_pkt_i
  ,output logic                                fwd_ready_o

  ,input  logic                                rev_v_i
  ,input  mc_pkg::mc_rev_pkt_s                 rev_pkt_i
  ,output logic                                rev_ready_o

  // Core side outputs
  ,output logic                                fwd_v_o
  ,output mc_pkg::mc_fwd_pkt_s                 fwd_pkt_o
  ,input  logic                                fwd_ready_i

  ,output logic                                rev_v_o
  ,output mc_pkg::mc_rev_pkt_s                 rev_pkt_o
  ,input  logic                                rev_ready_i

  // Chip-to-chip link
  ,output logic                                link_v_o
  ,output link_pkg::link_flit_s                link_flit_o
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]   link_credit_i

  ,input  logic                                link_v_i
  ,input  link_pkg::link_flit_s                link_flit_i
  ,output logic [link_pkg::NUM_CHANNELS-1:0]   link_credit_o
  );

  logic [link_pkg::NUM_CHANNELS-1:0]                           tx_v;
  logic [link_pkg::NUM_CHANNELS-1:0]                           tx_ready;
  logic [link_pkg::NUM_CHANNELS-1:0][link_pkg::FLIT_WIDTH-1:0] tx_data;
  logic [link_pkg::NUM_CHANNELS-1:0]                           rx_v;
  logic [link_pkg::NUM_CHANNELS-1:0]                           rx_ready;
  logic [link_pkg::NUM_CHANNELS-1:0][link_pkg::FLIT_WIDTH-1:0] rx_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet to flits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flit_serializer
 #(.payload_t    (mc_pkg::mc_fwd_pkt_s)
  ) fwd_ser
  (.clk_i        (clk_i)
  ,.rst_i        (rst_i)
  ,.v_i          (fwd_v_i)
  ,.payload_i    (fwd_pkt_i)
  ,.ready_o      (fwd_ready_o)
  ,.flit_v_o     (tx_v    [link_pkg::CHAN_FWD])
  ,.flit_data_o  (tx_data [link_pkg::CHAN_FWD])
  ,.flit_ready_i (tx_ready[link_pkg::CHAN_FWD])
  );

  flit_serializer
 #(.payload_t    (mc_pkg::mc_rev_pkt_s)
  ) rev_ser
  (.clk_i        (clk_i)
  ,.rst_i        (rst_i)
  ,.v_i          (rev_v_i)
  ,.payload_i    (rev_pkt_i)
  ,.ready_o      (rev_ready_o)
  ,.flit_v_o     (tx_v    [link_pkg::CHAN_REV])
  ,.flit_data_o  (tx_data [link_pkg::CHAN_REV])
  ,.flit_ready_i (tx_ready[link_pkg::CHAN_REV])
  );

  channel_tunnel tunnel
  (.clk_i         (clk_i)
  ,.rst_i         (rst_i)
  ,.tx_v_i        (tx_v)
  ,.tx_data_i     (tx_data)
  ,.tx_ready_o    (tx_ready)
  ,.rx_v_o        (rx_v)
  ,.rx_data_o     (rx_data)
  ,.rx_ready_i    (rx_ready)
  ,.link_v_o      (link_v_o)
  ,.link_flit_o   (link_flit_o)
  ,.link_credit_i (link_credit_i)
  ,.link_v_i      (link_v_i)
  ,.link_flit_i   (link_flit_i)
  ,.link_credit_o (link_credit_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flits to packet
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flit_deserializer
 #(.payload_t    (mc_pkg::mc_fwd_pkt_s)
  ) fwd_des
  (.clk_i        (clk_i)
  ,.rst_i        (rst_i)
  ,.flit_v_i     (rx_v    [link_pkg::CHAN_FWD])
  ,.flit_data_i  (rx_data [link_pkg::CHAN_FWD])
  ,.flit_ready_o (rx_ready[link_pkg::CHAN_FWD])
  ,.v_o          (fwd_v_o)
  ,.payload_o    (fwd_pkt_o)
  ,.ready_i      (fwd_ready_i)
  );

  flit_deserializer
 #(.payload_t    (mc_pkg::mc_rev_pkt_s)
  ) rev_des
  (.clk_i        (clk_i)
  ,.rst_i        (rst_i)
  ,.flit_v_i     (rx_v    [link_pkg::CHAN_REV])
  ,.flit_data_i  (rx_data [link_pkg::CHAN_REV])
  ,.flit_ready_o (rx_ready[link_pkg::CHAN_REV])
  ,.v_o          (rev_v_o)
  ,.payload_o    (rev_pkt_o)
  ,.ready_i      (rev_ready_i)
  );

endmodule

//--- hdl/channel_tunnel.sv
`timescale 1ns/1ps

module channel_tunnel
  (input  logic                                                         clk_i
  ,input  logic                                                         rst_i

  // Core side, one lane per channel
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]                            tx_v_i
  ,input  logic [link_pkg::NUM_CHANNELS-1:0][link_pkg::FLIT_WIDTH-1:0]  tx_data_i
  ,output logic [link_pkg::NUM_CHANNELS-1:0]                            tx_ready_o

  ,output logic [link_pkg::NUM_CHANNELS-1:0]                            rx_v_o
  ,output logic [link_pkg::NUM_CHANNELS-1:0][link_pkg::FLIT_WIDTH-1:0]  rx_data_o
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]                            rx_ready_i

  // Link side
  ,output logic                                                         link_v_o
  ,output link_pkg::link_flit_s                                         link_flit_o
  ,input  logic [link_pkg::NUM_CHANNELS-1:0]                            link_credit_i

  ,input  logic                                                         link_v_i
  ,input  link_pkg::link_flit_s                                         link_flit_i
  ,output logic [link_pkg::NUM_CHANNELS-1:0]                            link_credit_o
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sender
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [link_pkg::CREDIT_WIDTH-1:0] credit_r [link_pkg::NUM_CHANNELS];
  logic [link_pkg::NUM_CHANNELS-1:0] eligible;
  logic [link_pkg::CHAN_WIDTH-1:0]   rr_ptr_r;    // Channel with first pick
  logic [link_pkg::CHAN_WIDTH-1:0]   win_chan;
  logic                              win_v;
  logic                              link_v_r;
  link_pkg::link_flit_s              link_flit_r;

  always_comb
  begin
    for (int c = 0; c < link_pkg::NUM_CHANNELS; c++)
      eligible[c] = tx_v_i[c] & (credit_r[c] != '0);
  end

  // Walk from the lowest priority up so the nearest eligible channel wins
  always_comb
  begin
    logic [link_pkg::CHAN_WIDTH-1:0] idx;
    win_v    = 1'b0;
    win_chan = rr_ptr_r;
    for (int i = link_pkg::NUM_CHANNELS - 1; i >= 0; i--)
    begin
      idx = link_pkg::CHAN_WIDTH'((int'(rr_ptr_r) + i) % link_pkg::NUM_CHANNELS);
      if (eligible[idx])
      begin
        win_v    = 1'b1;
        win_chan = idx;
      end
    end
  end

  always_comb
  begin
    for (int c = 0; c < link_pkg::NUM_CHANNELS; c++)
      tx_ready_o[c] = win_v & (int'(win_chan) == c);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rr_ptr_r <= '0;
      link_v_r <= 1'b0;
    end
    else
    begin
      link_v_r <= win_v;
      if (win_v)
        rr_ptr_r <= (int'(win_chan) == link_pkg::NUM_CHANNELS - 1) ? '0 : win_chan + 1'b1;
    end
  end

  // Send and returning credit may meet in one cycle
  always_ff @(posedge clk_i)
  begin
    for (int c = 0; c < link_pkg::NUM_CHANNELS; c++)
    begin
      if (rst_i)
        credit_r[c] <= link_pkg::CREDIT_MAX;
      else if (tx_ready_o[c] & ~link_credit_i[c])
        credit_r[c] <= credit_r[c] - 1'b1;
      else if (link_credit_i[c] & ~tx_ready_o[c])
        credit_r[c] <= credit_r[c] + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (win_v)
    begin
      link_flit_r.chan <= win_chan;
      link_flit_r.data <= tx_data_i[win_chan];
    end
  end

  assign link_v_o    = link_v_r;
  assign link_flit_o = link_flit_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receiver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [link_pkg::NUM_CHANNELS-1:0] fifo_push;
  logic [link_pkg::NUM_CHANNELS-1:0] fifo_pop;
  logic [link_pkg::NUM_CHANNELS-1:0] fifo_full;
  logic [link_pkg::NUM_CHANNELS-1:0] link_credit_r;

  for (genvar c = 0; c < link_pkg::NUM_CHANNELS; c++)
  begin : g_rx
    assign fifo_push[c] = link_v_i & (int'(link_flit_i.chan) == c);   // Steer by tag
    assign fifo_pop[c]  = rx_v_o[c] & rx_ready_i[c];

    flit_fifo rx_fifo
      (.clk_i  (clk_i)
      ,.rst_i  (rst_i)
      ,.push_i (fifo_push[c])
      ,.data_i (link_flit_i.data)
      ,.full_o (fifo_full[c])
      ,.v_o    (rx_v_o[c])
      ,.data_o (rx_data_o[c])
      ,.pop_i  (fifo_pop[c])
      );
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      link_credit_r <= '0;
    else
      link_credit_r <= fifo_pop;   // One credit per drained flit
  end

  assign link_credit_o = link_credit_r;

endmodule

//--- hdl/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo
  (input  logic                            clk_i
  ,input  logic                            rst_i

  ,input  logic                            push_i
  ,input  logic [link_pkg::FLIT_WIDTH-1:0] data_i
  ,output logic                            full_o

  ,output logic                            v_o
  ,output logic [link_pkg::FLIT_WIDTH-1:0] data_o
  ,input  logic                            pop_i
  );

  logic [link_pkg::FLIT_WIDTH-1:0]     mem_r [link_pkg::LINK_CREDITS];
  logic [link_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr_r;
  logic [link_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr_r;
  logic [link_pkg::CREDIT_WIDTH-1:0]   count_r;   // Occupancy

  function automatic logic [link_pkg::FIFO_PTR_WIDTH-1:0] ptr_next
    (input logic [link_pkg::FIFO_PTR_WIDTH-1:0] ptr);
    if (int'(ptr) == link_pkg::LINK_CREDITS - 1)
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o = (count_r == link_pkg::CREDIT_MAX);
  assign v_o    = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= ptr_next(wr_ptr_r);
      if (pop_i)
        rd_ptr_r <= ptr_next(rd_ptr_r);
      if (push_i & ~pop_i)
        count_r <= count_r + 1'b1;
      else if (pop_i & ~push_i)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

//--- hdl/flit_deserializer.sv
`timescale 1ns/1ps

module flit_deserializer
 #(parameter type payload_t = logic [link_pkg::FLIT_WIDTH-1:0]
  )
  (input  logic                            clk_i
  ,input  logic                            rst_i

  ,input  logic                            flit_v_i
  ,input  logic [link_pkg::FLIT_WIDTH-1:0] flit_data_i
  ,output logic                            flit_ready_o

  ,output logic                            v_o
  ,output payload_t                        payload_o
  ,input  logic                            ready_i
  );

  localparam int PAYLOAD_WIDTH = $bits(payload_t);
  localparam int NUM_FLITS     = (PAYLOAD_WIDTH + link_pkg::FLIT_WIDTH - 1) / link_pkg::FLIT_WIDTH;
  localparam int PAD_WIDTH     = NUM_FLITS * link_pkg::FLIT_WIDTH;
  localparam int COUNT_WIDTH   = $clog2(NUM_FLITS + 1);

  localparam logic [COUNT_WIDTH-1:0] COUNT_FULL = COUNT_WIDTH'(NUM_FLITS);

  logic [PAD_WIDTH-1:0]   asm_r;    // Assembly register
  logic [COUNT_WIDTH-1:0] count_r;  // Flits gathered so far
  logic                   take;
  logic                   done;

  assign v_o          = (count_r == COUNT_FULL);
  assign flit_ready_o = ~v_o;       // Stall while a packet waits
  assign take         = flit_v_i & flit_ready_o;
  assign done         = v_o & ready_i;

  // Pad bits sit at the top and are dropped here
  assign payload_o = payload_t'(asm_r[PAYLOAD_WIDTH-1:0]);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      count_r <= '0;
    else if (done)
      count_r <= '0;
    else if (take)
      count_r <= count_r + 1'b1;
  end

  // New flit enters at the top, so the first one lands lowest
  always_ff @(posedge clk_i)
  begin
    if (take)
      asm_r <= PAD_WIDTH'({flit_data_i, asm_r} >> link_pkg::FLIT_WIDTH);
  end

endmodule

//--- hdl/flit_serializer.sv
`timescale 1ns/1ps

module flit_serializer
 #(parameter type payload_t = logic [link_pkg::FLIT_WIDTH-1:0]
  )
  (input  logic                            clk_i
  ,input  logic                            rst_i

  ,input  logic                            v_i
  ,input  payload_t                        payload_i
  ,output logic                            ready_o

  ,output logic                            flit_v_o
  ,output logic [link_pkg::FLIT_WIDTH-1:0] flit_data_o
  ,input  logic                            flit_ready_i
  );

  localparam int PAYLOAD_WIDTH = $bits(payload_t);
  localparam int NUM_FLITS     = (PAYLOAD_WIDTH + link_pkg::FLIT_WIDTH - 1) / link_pkg::FLIT_WIDTH;
  localparam int PAD_WIDTH     = NUM_FLITS * link_pkg::FLIT_WIDTH;
  localparam int COUNT_WIDTH   = $clog2(NUM_FLITS + 1);

  logic [PAD_WIDTH-1:0]   padded;
  logic [PAD_WIDTH-1:0]   shift_r;
  logic [COUNT_WIDTH-1:0] count_r;  // Flits still to send
  logic                   accept;
  logic                   take;

  // Zero fill above the payload so the final flit is padded
  always_comb
  begin
    padded                     = '0;
    padded[PAYLOAD_WIDTH-1:0]  = payload_i;
  end

  assign flit_v_o    = (count_r != '0);
  assign flit_data_o = shift_r[link_pkg::FLIT_WIDTH-1:0];  // Low flit first
  assign take        = flit_v_o & flit_ready_i;

  // Idle, or the last flit leaves this cycle
  assign ready_o = (count_r == '0) | ((count_r == COUNT_WIDTH'(1)) & flit_ready_i);
  assign accept  = v_i & ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      count_r <= '0;
    else if (accept)
      count_r <= COUNT_WIDTH'(NUM_FLITS);
    else if (take)
      count_r <= count_r - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      shift_r <= padded;
    else if (take)
      shift_r <= shift_r >> link_pkg::FLIT_WIDTH;
  end

endmodule

//--- hdl/mc_pkg.sv
package mc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // On-chip network field widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int MC_OP_WIDTH       = 4;
  localparam int MC_ADDR_WIDTH     = 16;
  localparam int MC_DATA_WIDTH     = 32;
  localparam int MC_X_CORD_WIDTH   = 4;
  localparam int MC_Y_CORD_WIDTH   = 4;
  localparam int MC_RET_TYPE_WIDTH = 2;

  // Forward request, 60 bits
  typedef struct packed {
    logic [MC_OP_WIDTH-1:0]     op;
    logic [MC_ADDR_WIDTH-1:0]   addr;
    logic [MC_DATA_WIDTH-1:0]   data;
    logic [MC_X_CORD_WIDTH-1:0] x_cord;   // Source tile
    logic [MC_Y_CORD_WIDTH-1:0] y_cord;
  } mc_fwd_pkt_s;

  // Return packet, 42 bits
  typedef struct packed {
    logic [MC_RET_TYPE_WIDTH-1:0] ret_type;
    logic [MC_DATA_WIDTH-1:0]     data;
    logic [MC_X_CORD_WIDTH-1:0]   x_cord; // Requester to return to
    logic [MC_Y_CORD_WIDTH-1:0]   y_cord;
  } mc_rev_pkt_s;

endpackage

//--- hdl/link_pkg.sv
package link_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Link geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int FLIT_WIDTH   = 16;                      // Payload bits per flit
  localparam int NUM_CHANNELS = 2;
  localparam int CHAN_WIDTH   = $clog2(NUM_CHANNELS);

  // Channel numbering on the link
  localparam logic [CHAN_WIDTH-1:0] CHAN_FWD = 1'b0;     // Forward requests
  localparam logic [CHAN_WIDTH-1:0] CHAN_REV = 1'b1;     // Reverse returns

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Credit flow
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Receive buffer depth per channel, also the sender's starting credit
  localparam int LINK_CREDITS = 4;
  localparam int CREDIT_WIDTH = 3;
  localparam int FIFO_PTR_WIDTH = $clog2(LINK_CREDITS);

  localparam logic [CREDIT_WIDTH-1:0] CREDIT_MAX = CREDIT_WIDTH'(LINK_CREDITS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit on the wire
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [CHAN_WIDTH-1:0] chan;                         // Owning channel
    logic [FLIT_WIDTH-1:0] data;
  } link_flit_s;

endpackage
